/* compile.f */
+incdir+tb
src/laneExPkg.sv
src/laneShifter.sv
src/laneDecode.sv
src/laneExecute.sv
src/laneResult.sv
src/laneExTop.sv
tb/laneExTb.sv

/* src/laneDecode.sv */
////////////////////////////////////////////////////////////////////////////
// EX1 decode. Registers the op at the edge where inValid is sampled.
// A failed predicate or braFlush turns the op into opNop.
// opOpIxt only knows nop and brk, any other extension code faults.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module laneDecode (
	input  logic clock,
	input  logic rst,
	input  logic inValid,
	input  logic [7:0] opCmd,	// [7:6] cc, [5:0] opcode
	input  logic [7:0] opIxt,	// [7:6] reserved
	input  logic [laneExPkg::regIdWidth-1:0] regIdRm,
	input  logic srT,
	input  logic braFlush,
	output logic decValid,
	output laneExPkg::opCode decOp,
	output logic [5:0] decIxt,
	output laneExPkg::opClass decClass,
	output logic [laneExPkg::regIdWidth-1:0] decIdRm
);

	laneExPkg::condCode cond;
	laneExPkg::opCode opNext;
	laneExPkg::opClass classNext;
	logic enable;

	// predicate
	always_comb begin
		cond = laneExPkg::condCode'(opCmd[7:6]);
		case (cond)
			laneExPkg::ccAlways:  enable = 1'b1;
			laneExPkg::ccIfTrue:  enable = srT;
			laneExPkg::ccIfFalse: enable = !srT;
			default:              enable = 1'b0;	// ccNever
		endcase
		if (braFlush)
			enable = 1'b0;	// flushed ops never execute
	end

	// map raw opcode, then classify with its extension
	always_comb begin
		case (opCmd[5:0])
			laneExPkg::opNop, laneExPkg::opMovIr, laneExPkg::opShad,
			laneExPkg::opShld, laneExPkg::opShadQ, laneExPkg::opShldQ,
			laneExPkg::opConv, laneExPkg::opOpIxs, laneExPkg::opAlu3,
			laneExPkg::opMul3, laneExPkg::opFpu3, laneExPkg::opOpIxt:
				opNext = laneExPkg::opCode'(opCmd[5:0]);
			default: opNext = laneExPkg::opInvalid;	// unmapped encodings
		endcase
		if (!enable)
			opNext = laneExPkg::opNop;

		classNext = laneExPkg::classFault;	// anything not listed below
		case (opNext)
			laneExPkg::opNop: classNext = laneExPkg::classNone;
			laneExPkg::opShad, laneExPkg::opShld,
			laneExPkg::opShadQ, laneExPkg::opShldQ:
				classNext = laneExPkg::classResult;
			laneExPkg::opMovIr:
				if (opIxt[5:0] <= laneExPkg::ixtLdish32)
					classNext = laneExPkg::classResult;
			laneExPkg::opConv:
				if (opIxt[5:0] <= laneExPkg::ixtZxtL)
					classNext = laneExPkg::classResult;
			laneExPkg::opOpIxs: begin
				if (opIxt[5:0] == laneExPkg::ixtSysNop)
					classNext = laneExPkg::classNone;
				else if (opIxt[5:0] == laneExPkg::ixtSysMovT ||
						opIxt[5:0] == laneExPkg::ixtSysMovNT)
					classNext = laneExPkg::classResult;
			end
			laneExPkg::opOpIxt:	// brk stays a fault
				if (opIxt[5:0] == laneExPkg::ixtSysNop)
					classNext = laneExPkg::classNone;
			laneExPkg::opAlu3, laneExPkg::opFpu3:
				classNext = laneExPkg::classHeld;
			default: ;	// opMul3 and opInvalid fault
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst)
			decValid <= 1'b0;
		else
			decValid <= inValid;
	end

	// payload, qualified by decValid
	always_ff @(posedge clock) begin
		decOp    <= opNext;
		decIxt   <= opIxt[5:0];
		decClass <= classNext;
		decIdRm  <= regIdRm;
	end

	// an accepted op arrives fully known, else its class is a guess
	aOpKnown: assert property (@(posedge clock) disable iff (rst)
		inValid |-> !$isunknown({opCmd, opIxt[5:0], regIdRm, srT, braFlush}));

endmodule

/* src/laneExPkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared widths and encodings for the EX1 stage of a secondary issue lane.
// Opcode values outside opCode are decoded as opInvalid.
// Extension codes sit in the low 6 bits of opIxt. Bits [7:6] are reserved.
////////////////////////////////////////////////////////////////////////////

package laneExPkg;

	localparam int regIdWidth = 6;	// gpr id bits
	localparam int valWidth   = 64;	// gpr value bits

	// id 0 is the discard register, writes to it are dropped
	localparam logic [regIdWidth-1:0] regZero = '0;

	// opcode field, opCmd[5:0]
	typedef enum logic [5:0] {
		opNop     = 6'h00,
		opMovIr   = 6'h01,	// load / shift-in immediate
		opShad    = 6'h02,	// 32b arith shift
		opShld    = 6'h03,	// 32b logical shift
		opShadQ   = 6'h04,
		opShldQ   = 6'h05,
		opConv    = 6'h06,	// sign / zero extend
		opOpIxs   = 6'h07,	// single-source sys ops
		opAlu3    = 6'h08,
		opMul3    = 6'h09,	// no multiplier in this lane
		opFpu3    = 6'h0A,
		opOpIxt   = 6'h0B,
		opInvalid = 6'h3F
	} opCode;

	// condition field, opCmd[7:6]
	typedef enum logic [1:0] {
		ccAlways  = 2'b00,
		ccNever   = 2'b01,
		ccIfTrue  = 2'b10,
		ccIfFalse = 2'b11
	} condCode;

	typedef enum logic [5:0] {
		ixtSxtB = 6'h00,
		ixtSxtW = 6'h01,
		ixtSxtL = 6'h02,
		ixtZxtB = 6'h03,
		ixtZxtW = 6'h04,
		ixtZxtL = 6'h05
	} ixtConv;

	typedef enum logic [5:0] {
		ixtLdi     = 6'h00,	// plain load of Rt
		ixtLdish8  = 6'h01,
		ixtLdish16 = 6'h02,
		ixtLdish32 = 6'h03
	} ixtMovIr;

	// shared by opOpIxs and opOpIxt
	typedef enum logic [5:0] {
		ixtSysNop   = 6'h00,
		ixtSysMovT  = 6'h01,
		ixtSysMovNT = 6'h02,
		ixtSysBrk   = 6'h03
	} ixtSys;

	typedef enum logic [1:0] {
		classNone,	// no register effect
		classResult,	// finished in EX1
		classHeld,	// finished by a later stage
		classFault	// raises exHold
	} opClass;

endpackage

/* src/laneExTop.sv */
////////////////////////////////////////////////////////////////////////////
// EX1 stage top. Upstream starts with QueueDepth credits and gets one back
// per inCreditReturn. regIdRs, regIdRt and regValRm belong to the common
// lane interface and have no use in this stage.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module laneExTop #(
	parameter int QueueDepth = 4
) (
	input  logic clock,
	input  logic rst,
	input  logic inValid,
	input  logic [7:0] opCmd,
	input  logic [7:0] opIxt,
	input  logic [laneExPkg::regIdWidth-1:0] regIdRs,
	input  logic [laneExPkg::regIdWidth-1:0] regIdRt,
	input  logic [laneExPkg::regIdWidth-1:0] regIdRm,
	input  logic [laneExPkg::valWidth-1:0] regValRs,
	input  logic [laneExPkg::valWidth-1:0] regValRt,
	input  logic [laneExPkg::valWidth-1:0] regValRm,
	input  logic srT,
	input  logic braFlush,
	output logic outValid,
	output logic [laneExPkg::regIdWidth-1:0] outIdRn,
	output logic [laneExPkg::valWidth-1:0] outValRn,
	output logic [laneExPkg::regIdWidth-1:0] outHeldId,
	input  logic outCredit,
	output logic inCreditReturn,
	output logic exHold
);

	logic decValid;
	laneExPkg::opCode decOp;
	logic [5:0] decIxt;
	laneExPkg::opClass decClass;
	logic [laneExPkg::regIdWidth-1:0] decIdRm;
	logic exValid, exFault;
	logic [laneExPkg::regIdWidth-1:0] exIdRn, exHeldId;
	logic [laneExPkg::valWidth-1:0] exValRn;

	laneDecode decode0 (.clock, .rst, .inValid, .opCmd, .opIxt, .regIdRm, .srT, .braFlush,
		.decValid, .decOp, .decIxt, .decClass, .decIdRm);

	laneExecute execute0 (.clock, .rst, .decValid, .decOp, .decIxt, .decClass, .decIdRm,
		.regValRs, .regValRt, .srT, .exValid, .exIdRn, .exHeldId, .exValRn, .exFault);

	laneResult #(.QueueDepth(QueueDepth)) result0 (.clock, .rst, .exValid, .exIdRn,
		.exValRn, .exHeldId, .exFault, .outCredit, .outValid, .outIdRn, .outHeldId,
		.outValRn, .inCreditReturn, .exHold);

endmodule

/* src/laneExecute.sv */
////////////////////////////////////////////////////////////////////////////
// EX1 execute. Source values and T are captured at the decode edge, the
// result is registered one edge later. Every decoded op yields one exValid.
// Only result-class ops name a destination, held ops name exHeldId.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module laneExecute (
	input  logic clock,
	input  logic rst,
	input  logic decValid,
	input  laneExPkg::opCode decOp,
	input  logic [5:0] decIxt,
	input  laneExPkg::opClass decClass,
	input  logic [laneExPkg::regIdWidth-1:0] decIdRm,
	input  logic [laneExPkg::valWidth-1:0] regValRs,
	input  logic [laneExPkg::valWidth-1:0] regValRt,
	input  logic srT,
	output logic exValid,
	output logic [laneExPkg::regIdWidth-1:0] exIdRn,
	output logic [laneExPkg::regIdWidth-1:0] exHeldId,
	output logic [laneExPkg::valWidth-1:0] exValRn,
	output logic exFault
);

	logic [laneExPkg::valWidth-1:0] opRs, opRt;	// aligned with dec*
	logic opT;
	logic [laneExPkg::valWidth-1:0] shOut, valNext;
	logic shQuad, shArith;

	// operand capture, same edge as laneDecode
	always_ff @(posedge clock) begin
		opRs <= regValRs;
		opRt <= regValRt;
		opT  <= srT;
	end

	assign shQuad  = (decOp == laneExPkg::opShadQ) || (decOp == laneExPkg::opShldQ);
	assign shArith = (decOp == laneExPkg::opShad) || (decOp == laneExPkg::opShadQ);

	laneShifter shift0 (
		.value   (opRs),
		.amount  (opRt[7:0]),	// low byte of Rt is the amount
		.isQuad  (shQuad),
		.isArith (shArith),
		.result  (shOut)
	);

	always_comb begin
		valNext = '0;
		case (decOp)
			laneExPkg::opShad, laneExPkg::opShld,
			laneExPkg::opShadQ, laneExPkg::opShldQ: valNext = shOut;
			laneExPkg::opMovIr:
				case (decIxt)	// Rs shifted up, Rt fills the low bits
					laneExPkg::ixtLdish8:  valNext = {opRs[55:0], opRt[7:0]};
					laneExPkg::ixtLdish16: valNext = {opRs[47:0], opRt[15:0]};
					laneExPkg::ixtLdish32: valNext = {opRs[31:0], opRt[31:0]};
					default:               valNext = opRt;	// ldi
				endcase
			laneExPkg::opConv:
				case (decIxt)
					laneExPkg::ixtSxtB: valNext = {{56{opRs[7]}}, opRs[7:0]};
					laneExPkg::ixtSxtW: valNext = {{48{opRs[15]}}, opRs[15:0]};
					laneExPkg::ixtSxtL: valNext = {{32{opRs[31]}}, opRs[31:0]};
					laneExPkg::ixtZxtB: valNext = {56'h0, opRs[7:0]};
					laneExPkg::ixtZxtW: valNext = {48'h0, opRs[15:0]};
					default:            valNext = {32'h0, opRs[31:0]};
				endcase
			laneExPkg::opOpIxs:	// movT or movNT, nop has no destination
				valNext = {63'h0, (decIxt == laneExPkg::ixtSysMovNT) ? !opT : opT};
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			exValid <= 1'b0;
			exFault <= 1'b0;
		end else begin
			exValid <= decValid;
			exFault <= decValid && (decClass == laneExPkg::classFault);
		end
	end

	always_ff @(posedge clock) begin
		exValRn  <= valNext;
		exIdRn   <= (decClass == laneExPkg::classResult) ? decIdRm : laneExPkg::regZero;
		exHeldId <= (decClass == laneExPkg::classHeld) ? decIdRm : laneExPkg::regZero;
	end

endmodule

/* src/laneResult.sv */
////////////////////////////////////////////////////////////////////////////
// Result queue of QueueDepth entries (2..16). Pops while downstream credit
// remains, returning one upstream credit per pop in the same cycle.
// Downstream credit counter is 8 bits, grants beyond 255 are not allowed.
// exHold is sticky until rst.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module laneResult #(
	parameter int QueueDepth = 4
) (
	input  logic clock,
	input  logic rst,
	input  logic exValid,
	input  logic [laneExPkg::regIdWidth-1:0] exIdRn,
	input  logic [laneExPkg::valWidth-1:0] exValRn,
	input  logic [laneExPkg::regIdWidth-1:0] exHeldId,
	input  logic exFault,
	input  logic outCredit,	// one grant per pulse
	output logic outValid,
	output logic [laneExPkg::regIdWidth-1:0] outIdRn,
	output logic [laneExPkg::regIdWidth-1:0] outHeldId,
	output logic [laneExPkg::valWidth-1:0] outValRn,
	output logic inCreditReturn,
	output logic exHold
);

	localparam int ptrW = $clog2(QueueDepth);
	localparam int cntW = $clog2(QueueDepth + 1);

	logic [laneExPkg::regIdWidth-1:0] memIdRn [QueueDepth];
	logic [laneExPkg::regIdWidth-1:0] memHeldId [QueueDepth];
	logic [laneExPkg::valWidth-1:0] memValRn [QueueDepth];
	logic [ptrW-1:0] wrPtr, rdPtr;
	logic [cntW-1:0] count;
	logic [7:0] credits;	// downstream grants not yet spent
	logic pop;

	assign pop            = (count != '0) && (credits != 8'd0);
	assign outValid       = pop;
	assign inCreditReturn = pop;	// slot freed, upstream may issue again
	assign outIdRn        = memIdRn[rdPtr];
	assign outHeldId      = memHeldId[rdPtr];
	assign outValRn       = memValRn[rdPtr];

	always_ff @(posedge clock) begin
		if (exValid) begin
			memIdRn[wrPtr]   <= exIdRn;
			memHeldId[wrPtr] <= exHeldId;
			memValRn[wrPtr]  <= exValRn;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			wrPtr   <= '0;
			rdPtr   <= '0;
			count   <= '0;
			credits <= 8'd0;
			exHold  <= 1'b0;
		end else begin
			if (exValid)	// wrap for non power of two depths
				wrPtr <= (wrPtr == ptrW'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == ptrW'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
			count   <= count + cntW'(exValid) - cntW'(pop);
			credits <= credits + 8'(outCredit) - 8'(pop);
			if (exFault)
				exHold <= 1'b1;	// sticky
		end
	end

	// upstream credits must keep the queue from overflowing
	aNoPushFull: assert property (@(posedge clock) disable iff (rst)
		exValid |-> (count != cntW'(QueueDepth)));

	// writeback must not grant past the 8-bit counter
	aCreditOverflow: assert property (@(posedge clock) disable iff (rst)
		(outCredit && !pop) |-> (credits != 8'hFF));

endmodule

/* src/laneShifter.sv */
////////////////////////////////////////////////////////////////////////////
// Combinational barrel shifter. Positive amount shifts left, negative right.
// Magnitude is masked to 5 bits (32b) or 6 bits (64b), so -128 acts as 0.
// 32b results are widened by sign (arith) or zeros (logical).
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module laneShifter (
	input  logic [laneExPkg::valWidth-1:0] value,
	input  logic signed [7:0] amount,
	input  logic isQuad,	// 64b op
	input  logic isArith,	// sign fill on right shift
	output logic [laneExPkg::valWidth-1:0] result
);

	logic [7:0] mag;
	logic [5:0] shAmt;
	logic [31:0] res32;
	logic [63:0] res64;

	always_comb begin
		mag = amount[7] ? (~amount + 8'd1) : amount;	// abs value
		shAmt = isQuad ? mag[5:0] : {1'b0, mag[4:0]};

		// 32b path on the low word only
		if (!amount[7])
			res32 = value[31:0] << shAmt;
		else if (isArith)
			res32 = $signed(value[31:0]) >>> shAmt;
		else
			res32 = value[31:0] >> shAmt;

		if (!amount[7])
			res64 = value << shAmt;
		else if (isArith)
			res64 = $signed(value) >>> shAmt;
		else
			res64 = value >> shAmt;

		if (isQuad)
			result = res64;
		else if (isArith)
			result = {{32{res32[31]}}, res32};	// sign-extend
		else
			result = {32'h0, res32};	// zero-extend
	end

endmodule

/* tb/laneExChecks.svh */
////////////////////////////////////////////////////////////////////////////
// Concurrent checks for the EX1 lane testbench, included into its module.
// Compares each outValid beat against the front of the model queue.
// Needs expId, expVal, expHeld, expFault, expEmpty, wbCredits, holdIssued.
////////////////////////////////////////////////////////////////////////////

	int errCount = 0;

	task automatic reportMismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		errCount++;
		$display("[ERROR] %s got %h expected %h", name, got, exp);
	endtask

	// destination id, regZero for disabled, held and fault ops
	aOutId: assert property (@(posedge clock) disable iff (rst)
		outValid |-> outIdRn == expId)
		else reportMismatch("outIdRn", $sampled(outIdRn), $sampled(expId));

	// value only means something when a destination is named
	aOutVal: assert property (@(posedge clock) disable iff (rst)
		(outValid && expId != laneExPkg::regZero) |-> outValRn == expVal)
		else reportMismatch("outValRn", $sampled(outValRn), $sampled(expVal));

	aOutHeld: assert property (@(posedge clock) disable iff (rst)
		outValid |-> outHeldId == expHeld)
		else reportMismatch("outHeldId", $sampled(outHeldId), $sampled(expHeld));

	aNoExtraOut: assert property (@(posedge clock) disable iff (rst)
		outValid |-> !expEmpty)
		else begin
			errCount++;
			$display("result seen with no op in flight");
		end

	// writeback grants not yet used
	aWbCredit: assert property (@(posedge clock) disable iff (rst)
		outValid |-> wbCredits > 0)
		else begin
			errCount++;
			$display("result sent without a writeback credit");
		end

	aReturnPair: assert property (@(posedge clock) disable iff (rst)
		inCreditReturn == outValid)
		else reportMismatch("inCreditReturn", $sampled(inCreditReturn),
			$sampled(outValid));

	// a fault op has passed the queue by the time it leaves
	aFaultHold: assert property (@(posedge clock) disable iff (rst)
		(outValid && expFault) |-> exHold)
		else reportMismatch("exHold", $sampled(exHold), 1);

	aHoldQuiet: assert property (@(posedge clock) disable iff (rst)
		!holdIssued |-> !exHold)
		else reportMismatch("exHold", $sampled(exHold), 0);

	aHoldSticky: assert property (@(posedge clock) disable iff (rst)
		exHold |=> exHold)
		else reportMismatch("exHold", $sampled(exHold), 1);

/* tb/laneExTb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the EX1 lane top. Random ops with a fixed seed, bursty
// writeback grants, model queue of expected results in issue order.
// Regular phases avoid faults, the middle phase raises exHold, then rst.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module laneExTb;

	localparam int depth = 4;	// queue depth under test

	logic clock, rst;
	logic inValid, srT, braFlush, outCredit;
	logic [7:0] opCmd, opIxt;
	logic [laneExPkg::regIdWidth-1:0] regIdRs, regIdRt, regIdRm;
	logic [laneExPkg::valWidth-1:0] regValRs, regValRt, regValRm;
	logic outValid, inCreditReturn, exHold;
	logic [laneExPkg::regIdWidth-1:0] outIdRn, outHeldId;
	logic [laneExPkg::valWidth-1:0] outValRn;

	int seed = 1680;
	int nIssued = 0, nOut = 0, nRet = 0;
	int upCredits = 0, wbCredits = 0, burst = 0;
	bit grantOn = 0, holdIssued = 0, timedOut = 0;

	// model queue, one entry per accepted op
	logic [5:0] idQ[$], heldQ[$];
	logic [63:0] valQ[$];
	bit faultQ[$];
	logic [5:0] expId, expHeld;	// front of queue
	logic [63:0] expVal;
	bit expFault, expEmpty = 1;

	`include "laneExChecks.svh"

	laneExTop #(.QueueDepth(depth)) dut0 (.clock, .rst, .inValid, .opCmd, .opIxt,
		.regIdRs, .regIdRt, .regIdRm, .regValRs, .regValRt, .regValRm, .srT, .braFlush,
		.outValid, .outIdRn, .outValRn, .outHeldId, .outCredit, .inCreditReturn, .exHold);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic int rnd(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic updateFront();
		expEmpty = (idQ.size() == 0);
		if (!expEmpty) begin
			expId    = idQ[0];
			expHeld  = heldQ[0];
			expVal   = valQ[0];
			expFault = faultQ[0];
		end
	endtask

	// expected outcome of one op, straight from the lane rules
	task automatic modelOp(input logic [7:0] cmd, input logic [7:0] ixt,
			input logic [5:0] rm, input logic [63:0] rs, input logic [63:0] rt,
			input bit t, input bit flush, output logic [5:0] id,
			output logic [5:0] held, output logic [63:0] val, output bit fault);
		bit en, quad, arith;
		int n, mag;
		logic [63:0] w;
		logic [5:0] x;
		x = ixt[5:0];
		id = 0;
		held = 0;
		val = 0;
		fault = 0;
		case (cmd[7:6])
			2'd0: en = 1;
			2'd2: en = t;
			2'd3: en = !t;
			default: en = 0;
		endcase
		if (!en || flush)
			return;	// becomes a nop
		case (cmd[5:0])
			laneExPkg::opNop: ;
			laneExPkg::opShad, laneExPkg::opShld, laneExPkg::opShadQ, laneExPkg::opShldQ: begin
				quad  = cmd[5:0] == laneExPkg::opShadQ || cmd[5:0] == laneExPkg::opShldQ;
				arith = cmd[5:0] == laneExPkg::opShad || cmd[5:0] == laneExPkg::opShadQ;
				n = $signed(rt[7:0]);	// signed amount
				mag = (n < 0 ? -n : n) & (quad ? 63 : 31);
				w = quad ? rs : (arith ? {{32{rs[31]}}, rs[31:0]} : {32'h0, rs[31:0]});
				if (n >= 0)
					w = w << mag;
				else if (arith)
					w = $signed(w) >>> mag;
				else
					w = w >> mag;
				if (quad)
					val = w;
				else if (arith)
					val = {{32{w[31]}}, w[31:0]};
				else
					val = {32'h0, w[31:0]};
				id = rm;
			end
			laneExPkg::opMovIr: begin
				id = rm;
				case (x)
					0: val = rt;
					1: val = (rs << 8) | 64'(rt[7:0]);
					2: val = (rs << 16) | 64'(rt[15:0]);
					3: val = (rs << 32) | 64'(rt[31:0]);
					default: begin
						id = 0;
						fault = 1;
					end
				endcase
			end
			laneExPkg::opConv: begin
				id = rm;
				case (x)
					0: val = 64'(signed'(rs[7:0]));
					1: val = 64'(signed'(rs[15:0]));
					2: val = 64'(signed'(rs[31:0]));
					3: val = 64'(rs[7:0]);
					4: val = 64'(rs[15:0]);
					5: val = 64'(rs[31:0]);
					default: begin
						id = 0;
						fault = 1;
					end
				endcase
			end
			laneExPkg::opOpIxs: begin
				if (x == 1 || x == 2) begin
					id = rm;
					val = 64'(x == 1 ? t : !t);	// movT or movNT
				end else if (x != 0)
					fault = 1;
			end
			laneExPkg::opOpIxt: fault = (x != 0);
			laneExPkg::opAlu3, laneExPkg::opFpu3: held = rm;
			default: fault = 1;	// mul3, invalid, unmapped
		endcase
	endtask

	// drives one op at a falling edge once an upstream credit is free
	task automatic issueOp(input logic [5:0] op, input logic [5:0] ixt, input bit anyCond);
		int waitCyc;
		logic [5:0] id, held;
		logic [63:0] val;
		bit fault;
		waitCyc = 0;
		if (timedOut)
			return;
		while (upCredits == 0 && waitCyc < 200) begin
			@(negedge clock);
			waitCyc++;
		end
		if (upCredits == 0) begin
			timedOut = 1;
			errCount++;
			$display("timeout waiting for an upstream credit");
			return;
		end
		opCmd = {(anyCond && rnd(2) == 1) ? 2'(rnd(4)) : 2'b00, op};
		opIxt = {2'(rnd(4)), ixt};	// reserved bits random
		regIdRm = 6'(1 + rnd(63));
		regIdRs = 6'(rnd(64));
		regIdRt = 6'(rnd(64));
		regValRs = {$random(seed), $random(seed)};
		regValRt = {$random(seed), $random(seed)};
		regValRm = {$random(seed), $random(seed)};
		srT = rnd(2);
		braFlush = anyCond && rnd(10) == 0;
		inValid = 1'b1;
		modelOp(opCmd, opIxt, regIdRm, regValRs, regValRt, srT, braFlush, id, held, val, fault);
		idQ.push_back(id);
		heldQ.push_back(held);
		valQ.push_back(val);
		faultQ.push_back(fault);
		holdIssued |= fault;
		upCredits--;
		nIssued++;
		updateFront();
		@(negedge clock);
		inValid = 1'b0;
	endtask

	task automatic issueRandom(input bit withFaults);
		int sel;
		sel = rnd(withFaults ? 12 : 10);
		case (sel)
			0: issueOp(laneExPkg::opNop, 6'h00, 1);
			1, 2, 3, 4: issueOp(6'(sel + 1), 6'(rnd(64)), 1);	// the four shifts
			5: issueOp(laneExPkg::opMovIr, 6'(rnd(4)), 1);
			6: issueOp(laneExPkg::opConv, 6'(rnd(6)), 1);
			7: issueOp(laneExPkg::opOpIxs, 6'(rnd(3)), 1);
			8: issueOp(laneExPkg::opAlu3, 6'(rnd(64)), 1);
			9: issueOp(laneExPkg::opFpu3, 6'(rnd(64)), 1);
			10: issueOp(laneExPkg::opOpIxt, 6'(rnd(4)), 1);
			default: issueOp(rnd(2) ? 6'(laneExPkg::opMul3) : 6'(32 + rnd(32)), 6'h00, 1);
		endcase
	endtask

	task automatic drain();
		int waitCyc;
		waitCyc = 0;
		if (timedOut)
			return;
		while (idQ.size() != 0 && waitCyc < 2000) begin
			@(negedge clock);
			waitCyc++;
		end
		if (idQ.size() != 0) begin
			timedOut = 1;
			errCount++;
			$display("timeout waiting for the result queue to drain");
		end
	endtask

	task automatic applyReset();
		grantOn = 0;
		rst = 1'b1;
		repeat (4) @(negedge clock);
		rst = 1'b0;
		holdIssued = 0;
		grantOn = 1;
	endtask

	// writeback grants in random bursts, at most 8 outstanding
	always @(negedge clock) begin
		if (!grantOn)
			outCredit = 1'b0;
		else if (burst > 0) begin
			outCredit = (wbCredits < 8);
			burst--;
		end else begin
			outCredit = 1'b0;
			if (rnd(4) == 0)
				burst = 1 + rnd(6);
		end
	end

	always @(posedge clock) begin
		if (rst) begin
			upCredits = depth;
			wbCredits = 0;
		end else begin
			if (outValid) begin
				nOut++;
				if (idQ.size() != 0) begin
					void'(idQ.pop_front());
					void'(heldQ.pop_front());
					void'(valQ.pop_front());
					void'(faultQ.pop_front());
				end
				updateFront();
			end
			if (inCreditReturn) begin
				nRet++;
				upCredits++;
			end
			wbCredits = wbCredits + int'(outCredit) - int'(outValid);
		end
	end

	initial begin
		rst = 1'b1;
		inValid = 1'b0;
		outCredit = 1'b0;
		opCmd = '0;
		opIxt = '0;
		regIdRs = '0;
		regIdRt = '0;
		regIdRm = '0;
		regValRs = '0;
		regValRt = '0;
		regValRm = '0;
		srT = 1'b0;
		braFlush = 1'b0;
		repeat (4) @(negedge clock);
		rst = 1'b0;
		grantOn = 1;
		repeat (300) issueRandom(0);
		drain();
		// fault first, then traffic with hold already set
		issueOp(laneExPkg::opInvalid, 6'h00, 0);
		repeat (100) issueRandom(1);
		issueOp(laneExPkg::opOpIxs, laneExPkg::ixtSysBrk, 0);
		drain();
		if (!timedOut && exHold !== 1'b1)
			reportMismatch("exHold", exHold, 1);
		applyReset();
		if (exHold !== 1'b0)
			reportMismatch("exHold", exHold, 0);
		repeat (100) issueRandom(0);
		drain();
		if (!timedOut && nOut != nIssued) begin
			errCount++;
			$display("%0d ops issued but %0d results seen", nIssued, nOut);
		end
		if (nRet != nOut) begin
			errCount++;
			$display("%0d credit returns for %0d results", nRet, nOut);
		end
		$display("errors=%0d issued=%0d results=%0d returns=%0d timeout=%0d",
			errCount, nIssued, nOut, nRet, timedOut);
		if (errCount == 0 && !timedOut)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
